// ==== common/coherence_config.svh ====
`ifndef COHERENCE_CONFIG_SVH
`define COHERENCE_CONFIG_SVH

// number of private L1 data caches on the bus
`define CU_CORE_NUMS 4

// must cover CU_CORE_NUMS
`define CU_CORE_ID_BITS 2

// physical address width
`define CU_XLEN 32

// one cache line in bits
`define CU_CLSIZE 128

`endif

// ==== common/coherence_pkg.sv ====
`include "coherence_config.svh"
`default_nettype none

package coherence_pkg;

    typedef logic [`CU_CORE_ID_BITS-1:0] core_id_t;
    typedef logic [`CU_XLEN-1:0]         addr_t;
    typedef logic [`CU_CLSIZE-1:0]       line_t;

    typedef struct packed {
        logic  rw_strobe;    // line miss
        logic  is_write;     // 1 = write
        logic  share_modify; // write hit on a shared line
        logic  replacement;  // evicted dirty line
        addr_t addr;
        line_t wb_line;
    } l1_req_t;

    typedef struct packed {
        logic  ready; // only from an L1 holding the line
        line_t line;
    } l1_snoop_rsp_t;

    typedef struct packed {
        logic  strobe;
        logic  invalidate;
        addr_t addr;
    } l1_probe_t;

    typedef struct packed {
        logic  ready;
        logic  exclusive;
        line_t line;
    } l1_grant_t;

    typedef struct packed {
        logic  write;       // level until L2 ready
        logic  replacement;
        line_t line;
        logic  read_strobe;
        logic  is_write;
        logic  invalidate;  // single pulse, no answer
        addr_t addr;
    } l2_req_t;

    typedef struct packed {
        logic  ready;
        logic  exclusive;
        line_t line;
    } l2_rsp_t;

    typedef struct packed {
        logic  strobe; // held until the controller acknowledges
        addr_t addr;
    } l2_inval_t;

    typedef enum logic [3:0] {
        cu_idle,
        cu_miss,
        cu_wait,
        cu_wait2,
        cu_wb_l2,
        cu_invalidate,
        cu_repl_delay,
        cu_replacement,
        cu_l2_invalidate,
        cu_release
    } cu_state_e;

endpackage

`default_nettype wire

// ==== coherence/l1_request_arbiter.sv ====
`include "coherence_config.svh"
`default_nettype none

module l1_request_arbiter (
    input  wire logic                    clk_i,
    input  wire logic                    rst_i,
    input  wire logic                    capture_i,
    input  wire coherence_pkg::l1_req_t  l1_req_i [0:`CU_CORE_NUMS-1],
    output logic                         have_wb_o,
    output logic                         have_inval_o,
    output logic                         have_rw_o,
    output coherence_pkg::core_id_t      wb_id_o,
    output coherence_pkg::core_id_t      inval_id_o,
    output coherence_pkg::core_id_t      rw_id_o
);

    logic [`CU_CORE_NUMS-1:0] wb_vec;
    logic [`CU_CORE_NUMS-1:0] inval_vec;
    logic [`CU_CORE_NUMS-1:0] rw_vec;

    // lowest index wins
    function automatic coherence_pkg::core_id_t lowest_set(
        input logic [`CU_CORE_NUMS-1:0] vec
    );
        coherence_pkg::core_id_t id;
        id = '0;
        for (int i = `CU_CORE_NUMS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                id = coherence_pkg::core_id_t'(i);
            end
        end
        return id;
    endfunction

    always_comb begin
        for (int i = 0; i < `CU_CORE_NUMS; i++) begin
            wb_vec[i]    = l1_req_i[i].replacement;
            inval_vec[i] = l1_req_i[i].share_modify;
            rw_vec[i]    = l1_req_i[i].rw_strobe;
        end
    end

    assign have_wb_o    = |wb_vec;
    assign have_inval_o = |inval_vec;
    assign have_rw_o    = |rw_vec;

    // ids follow the requests while idle, frozen during a transaction
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_id_o    <= '0;
            inval_id_o <= '0;
            rw_id_o    <= '0;
        end else if (capture_i) begin
            wb_id_o    <= lowest_set(wb_vec);
            inval_id_o <= lowest_set(inval_vec);
            rw_id_o    <= lowest_set(rw_vec);
        end
    end

endmodule

`default_nettype wire

// ==== coherence/coherence_fsm.sv ====
`default_nettype none

module coherence_fsm (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire logic                      have_wb_i,
    input  wire logic                      have_inval_i,
    input  wire logic                      have_rw_i,
    input  wire logic                      rw_is_write_i,
    input  wire coherence_pkg::l2_inval_t  l2_inval_i,
    input  wire logic                      peer_ready_i,
    input  wire logic                      l2_ready_i,
    output coherence_pkg::cu_state_e       state_o,
    output logic                           capture_o,
    output logic                           cu_l2_ready_o
);

    coherence_pkg::cu_state_e state_q;
    coherence_pkg::cu_state_e state_d;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= coherence_pkg::cu_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            coherence_pkg::cu_idle: begin
                if (l2_inval_i.strobe) begin
                    state_d = coherence_pkg::cu_l2_invalidate;
                end else if (have_wb_i) begin
                    state_d = coherence_pkg::cu_repl_delay;
                end else if (have_inval_i) begin
                    state_d = coherence_pkg::cu_invalidate;
                end else if (have_rw_i) begin
                    state_d = coherence_pkg::cu_miss;
                end
            end
            coherence_pkg::cu_miss: begin
                state_d = coherence_pkg::cu_wait; // probes go out here
            end
            coherence_pkg::cu_wait: begin
                state_d = coherence_pkg::cu_wait2;
            end
            coherence_pkg::cu_wait2: begin
                // a peer answer beats the L2
                if (peer_ready_i) begin
                    if (rw_is_write_i) begin
                        state_d = coherence_pkg::cu_release;
                    end else begin
                        state_d = coherence_pkg::cu_wb_l2; // clean copy goes to L2 too
                    end
                end else if (l2_ready_i) begin
                    state_d = coherence_pkg::cu_release;
                end
            end
            coherence_pkg::cu_wb_l2: begin
                if (l2_ready_i) begin
                    state_d = coherence_pkg::cu_release;
                end
            end
            coherence_pkg::cu_repl_delay: begin
                state_d = coherence_pkg::cu_replacement;
            end
            coherence_pkg::cu_replacement: begin
                if (l2_ready_i) begin
                    state_d = coherence_pkg::cu_release;
                end
            end
            coherence_pkg::cu_invalidate: begin
                state_d = coherence_pkg::cu_release;
            end
            coherence_pkg::cu_l2_invalidate: begin
                state_d = coherence_pkg::cu_release;
            end
            // gives the granted L1 one edge to drop its request
            coherence_pkg::cu_release: begin
                state_d = coherence_pkg::cu_idle;
            end
            default: begin
                state_d = coherence_pkg::cu_idle;
            end
        endcase
    end

    assign state_o       = state_q;
    assign capture_o     = state_q == coherence_pkg::cu_idle;
    assign cu_l2_ready_o = state_q == coherence_pkg::cu_l2_invalidate;

endmodule

`default_nettype wire

// ==== coherence/snoop_response_unit.sv ====
`include "coherence_config.svh"
`default_nettype none

module snoop_response_unit (
    input  wire logic                          clk_i,
    input  wire logic                          rst_i,
    input  wire coherence_pkg::cu_state_e      state_i,
    input  wire coherence_pkg::l1_req_t        l1_req_i [0:`CU_CORE_NUMS-1],
    input  wire coherence_pkg::core_id_t       rw_id_i,
    input  wire coherence_pkg::core_id_t       wb_id_i,
    input  wire coherence_pkg::core_id_t       inval_id_i,
    input  wire coherence_pkg::l1_snoop_rsp_t  l1_snoop_rsp_i [0:`CU_CORE_NUMS-1],
    input  wire coherence_pkg::l2_rsp_t        l2_rsp_i,
    input  wire coherence_pkg::addr_t          l2_inval_addr_i,
    output logic                               peer_ready_o,
    output coherence_pkg::line_t               peer_line_o,
    output coherence_pkg::l1_probe_t           l1_probe_o [0:`CU_CORE_NUMS-1],
    output coherence_pkg::l1_grant_t           l1_grant_o [0:`CU_CORE_NUMS-1]
);

    coherence_pkg::l1_req_t   rw_req;
    coherence_pkg::l1_req_t   inval_req;
    coherence_pkg::l1_probe_t probe_d [0:`CU_CORE_NUMS-1];
    coherence_pkg::l1_grant_t grant_d [0:`CU_CORE_NUMS-1];

    assign rw_req    = l1_req_i[rw_id_i];
    assign inval_req = l1_req_i[inval_id_i];

    // lowest answering peer, scanned from the top
    always_comb begin
        peer_ready_o = 1'b0;
        peer_line_o  = '0;
        for (int i = `CU_CORE_NUMS - 1; i >= 0; i--) begin
            if (l1_snoop_rsp_i[i].ready) begin
                peer_ready_o = 1'b1;
                peer_line_o  = l1_snoop_rsp_i[i].line;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `CU_CORE_NUMS; i++) begin
            probe_d[i] = '0;
            grant_d[i] = '0;
            case (state_i)
                coherence_pkg::cu_miss: begin
                    probe_d[i].strobe     = coherence_pkg::core_id_t'(i) != rw_id_i;
                    probe_d[i].invalidate = probe_d[i].strobe && rw_req.is_write;
                    probe_d[i].addr       = rw_req.addr;
                end
                coherence_pkg::cu_invalidate: begin
                    probe_d[i].strobe     = coherence_pkg::core_id_t'(i) != inval_id_i;
                    probe_d[i].invalidate = probe_d[i].strobe;
                    probe_d[i].addr       = inval_req.addr;
                    grant_d[i].ready      = coherence_pkg::core_id_t'(i) == inval_id_i;
                end
                coherence_pkg::cu_l2_invalidate: begin
                    probe_d[i].strobe     = 1'b1; // requester included
                    probe_d[i].invalidate = 1'b1;
                    probe_d[i].addr       = l2_inval_addr_i;
                end
                coherence_pkg::cu_wait2: begin
                    if (coherence_pkg::core_id_t'(i) == rw_id_i) begin
                        if (peer_ready_o) begin
                            grant_d[i].ready = 1'b1; // shared copy, never exclusive
                            grant_d[i].line  = peer_line_o;
                        end else if (l2_rsp_i.ready) begin
                            grant_d[i].ready     = 1'b1;
                            grant_d[i].exclusive = l2_rsp_i.exclusive;
                            grant_d[i].line      = l2_rsp_i.line;
                        end
                    end
                end
                coherence_pkg::cu_replacement: begin
                    grant_d[i].ready = l2_rsp_i.ready && coherence_pkg::core_id_t'(i) == wb_id_i;
                end
                default: begin
                    probe_d[i] = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `CU_CORE_NUMS; i++) begin
            if (rst_i) begin
                l1_probe_o[i] <= '0;
                l1_grant_o[i] <= '0;
            end else begin
                l1_probe_o[i] <= probe_d[i];
                l1_grant_o[i] <= grant_d[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== coherence/l2_port.sv ====
`include "coherence_config.svh"
`default_nettype none

module l2_port (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire coherence_pkg::cu_state_e  state_i,
    input  wire coherence_pkg::l1_req_t    l1_req_i [0:`CU_CORE_NUMS-1],
    input  wire coherence_pkg::core_id_t   rw_id_i,
    input  wire coherence_pkg::core_id_t   wb_id_i,
    input  wire coherence_pkg::core_id_t   inval_id_i,
    input  wire logic                      peer_ready_i,
    input  wire coherence_pkg::line_t      peer_line_i,
    input  wire coherence_pkg::l2_rsp_t    l2_rsp_i,
    output coherence_pkg::l2_req_t         l2_req_o
);

    coherence_pkg::l1_req_t rw_req;
    coherence_pkg::l1_req_t wb_req;
    coherence_pkg::l1_req_t inval_req;

    logic wr_q;
    logic repl_q;
    logic rd_q;
    logic inv_q;
    logic rd_is_write_q;
    logic peer_fill;
    logic write_state;
    logic read_pending;

    coherence_pkg::addr_t rd_addr_q;
    coherence_pkg::addr_t inv_addr_q;
    coherence_pkg::addr_t buf_addr_q;
    coherence_pkg::line_t buf_line_q;

    assign rw_req    = l1_req_i[rw_id_i];
    assign wb_req    = l1_req_i[wb_id_i];
    assign inval_req = l1_req_i[inval_id_i];

    assign peer_fill    = state_i == coherence_pkg::cu_wait2 && peer_ready_i && !rw_req.is_write;
    assign write_state  = state_i == coherence_pkg::cu_wb_l2
                       || state_i == coherence_pkg::cu_replacement;
    assign read_pending = state_i == coherence_pkg::cu_wait2 && !peer_ready_i && !l2_rsp_i.ready;

    // write-back buffer, the requester may drop its request meanwhile
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            buf_addr_q <= '0;
            buf_line_q <= '0;
        end else if (peer_fill) begin
            buf_addr_q <= rw_req.addr;
            buf_line_q <= peer_line_i;
        end else if (state_i == coherence_pkg::cu_repl_delay) begin
            buf_addr_q <= wb_req.addr;
            buf_line_q <= wb_req.wb_line;
        end else if (l2_rsp_i.ready) begin
            buf_addr_q <= '0;
            buf_line_q <= '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_q   <= 1'b0;
            repl_q <= 1'b0;
            rd_q   <= 1'b0;
            inv_q  <= 1'b0;
        end else begin
            wr_q   <= write_state && !l2_rsp_i.ready;
            repl_q <= state_i == coherence_pkg::cu_replacement && !l2_rsp_i.ready;
            rd_q   <= read_pending; // re-issued each cycle until someone answers
            inv_q  <= state_i == coherence_pkg::cu_invalidate;
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_pending) begin
            rd_addr_q     <= rw_req.addr;
            rd_is_write_q <= rw_req.is_write;
        end
        if (state_i == coherence_pkg::cu_invalidate) begin
            inv_addr_q <= inval_req.addr;
        end
    end

    always_comb begin
        l2_req_o             = '0;
        l2_req_o.write       = wr_q;
        l2_req_o.replacement = repl_q;
        l2_req_o.line        = buf_line_q;
        l2_req_o.read_strobe = rd_q;
        l2_req_o.is_write    = rd_q && rd_is_write_q;
        l2_req_o.invalidate  = inv_q;
        // invalidate, then read, then write
        if (inv_q) begin
            l2_req_o.addr = inv_addr_q;
        end else if (rd_q) begin
            l2_req_o.addr = rd_addr_q;
        end else if (wr_q) begin
            l2_req_o.addr = buf_addr_q;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/coherence_unit.sv ====
`include "coherence_config.svh"
`default_nettype none

module coherence_unit (
    input  wire logic                          clk_i,
    input  wire logic                          rst_i,
    input  wire coherence_pkg::l1_req_t        l1_req_i [0:`CU_CORE_NUMS-1],
    input  wire coherence_pkg::l1_snoop_rsp_t  l1_snoop_rsp_i [0:`CU_CORE_NUMS-1],
    output coherence_pkg::l1_probe_t           l1_probe_o [0:`CU_CORE_NUMS-1],
    output coherence_pkg::l1_grant_t           l1_grant_o [0:`CU_CORE_NUMS-1],
    input  wire coherence_pkg::l2_rsp_t        l2_rsp_i,
    input  wire coherence_pkg::l2_inval_t      l2_inval_i,
    output coherence_pkg::l2_req_t             l2_req_o,
    output logic                               cu_l2_ready_o
);

    logic                     have_wb;
    logic                     have_inval;
    logic                     have_rw;
    logic                     capture;
    logic                     peer_ready;
    coherence_pkg::core_id_t  wb_id;
    coherence_pkg::core_id_t  inval_id;
    coherence_pkg::core_id_t  rw_id;
    coherence_pkg::cu_state_e state;
    coherence_pkg::line_t     peer_line;

    l1_request_arbiter arbiter_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .capture_i    (capture),
        .l1_req_i     (l1_req_i),
        .have_wb_o    (have_wb),
        .have_inval_o (have_inval),
        .have_rw_o    (have_rw),
        .wb_id_o      (wb_id),
        .inval_id_o   (inval_id),
        .rw_id_o      (rw_id)
    );

    coherence_fsm fsm_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .have_wb_i     (have_wb),
        .have_inval_i  (have_inval),
        .have_rw_i     (have_rw),
        .rw_is_write_i (l1_req_i[rw_id].is_write),
        .l2_inval_i    (l2_inval_i),
        .peer_ready_i  (peer_ready),
        .l2_ready_i    (l2_rsp_i.ready),
        .state_o       (state),
        .capture_o     (capture),
        .cu_l2_ready_o (cu_l2_ready_o)
    );

    snoop_response_unit snoop_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .state_i         (state),
        .l1_req_i        (l1_req_i),
        .rw_id_i         (rw_id),
        .wb_id_i         (wb_id),
        .inval_id_i      (inval_id),
        .l1_snoop_rsp_i  (l1_snoop_rsp_i),
        .l2_rsp_i        (l2_rsp_i),
        .l2_inval_addr_i (l2_inval_i.addr),
        .peer_ready_o    (peer_ready),
        .peer_line_o     (peer_line),
        .l1_probe_o      (l1_probe_o),
        .l1_grant_o      (l1_grant_o)
    );

    l2_port l2_port_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .state_i      (state),
        .l1_req_i     (l1_req_i),
        .rw_id_i      (rw_id),
        .wb_id_i      (wb_id),
        .inval_id_i   (inval_id),
        .peer_ready_i (peer_ready),
        .peer_line_i  (peer_line),
        .l2_rsp_i     (l2_rsp_i),
        .l2_req_o     (l2_req_o)
    );

endmodule

`default_nettype wire

// ==== testbench/coherence_tests.svh ====
function automatic logic [`CU_CORE_NUMS-1:0] others_mask(input int core);
    logic [`CU_CORE_NUMS-1:0] m;
    m       = '1;
    m[core] = 1'b0;
    return m;
endfunction

function automatic coherence_pkg::l1_req_t make_req(input logic rw, input logic wr,
        input logic sm, input logic repl, input coherence_pkg::addr_t addr,
        input coherence_pkg::line_t wb);
    coherence_pkg::l1_req_t r;
    r.rw_strobe    = rw;
    r.is_write     = wr;
    r.share_modify = sm;
    r.replacement  = repl;
    r.addr         = addr;
    r.wb_line      = wb;
    return r;
endfunction

task automatic check_probes(input logic [`CU_CORE_NUMS-1:0] mask, input logic inval,
                            input coherence_pkg::addr_t addr);
    for (int i = 0; i < `CU_CORE_NUMS; i++) begin
        check_value($sformatf("probe strobe %0d", i), mask[i], l1_probe[i].strobe);
        check_value($sformatf("probe invalidate %0d", i), mask[i] & inval,
                    l1_probe[i].invalidate);
        if (mask[i]) begin
            check_value($sformatf("probe addr %0d", i), addr, l1_probe[i].addr);
        end
    end
endtask

task automatic check_grant(input int core, input logic check_data, input logic excl,
                           input coherence_pkg::line_t line);
    for (int i = 0; i < `CU_CORE_NUMS; i++) begin
        check_value($sformatf("grant ready %0d", i), i == core, l1_grant[i].ready);
    end
    if (check_data) begin
        check_value("grant exclusive", excl, l1_grant[core].exclusive);
        check_value("grant line", line, l1_grant[core].line);
    end
endtask

// one-cycle answer from every peer in mask
task automatic snoop_answer(input logic [`CU_CORE_NUMS-1:0] mask);
    @(posedge clk_i);
    for (int i = 0; i < `CU_CORE_NUMS; i++) begin
        if (mask[i]) begin
            l1_snoop_rsp[i].ready <= 1'b1;
            l1_snoop_rsp[i].line  <= held_line[i];
        end
    end
    @(posedge clk_i);
    for (int i = 0; i < `CU_CORE_NUMS; i++) begin
        l1_snoop_rsp[i] <= '0;
    end
endtask

task automatic l2_answer(input logic excl, input coherence_pkg::line_t line);
    @(posedge clk_i);
    l2_rsp.ready     <= 1'b1;
    l2_rsp.exclusive <= excl;
    l2_rsp.line      <= line;
    @(negedge clk_i);
    for (int i = 0; i < `CU_CORE_NUMS; i++) begin
        check_value("grant during L2 ready", 1'b0, l1_grant[i].ready); // grant comes one edge later
    end
    @(posedge clk_i);
    l2_rsp <= '0;
endtask

// no peer holds the line, L2 answers the read
task automatic serve_miss_from_l2(input int core, input coherence_pkg::addr_t addr,
                                  input logic wr, input logic excl);
    coherence_pkg::line_t line;
    line = random_line();
    wait_for(EV_PROBE, core == 0 ? 1 : 0, "probe");
    check_probes(others_mask(core), wr, addr);
    wait_for(EV_READ, 0, "L2 read");
    check_value("read addr", addr, l2_req.addr);
    check_value("read is_write", wr, l2_req.is_write);
    l2_answer(excl, line);
    wait_for(EV_GRANT, core, "grant");
    check_grant(core, 1'b1, excl, line);
    @(posedge clk_i);
    l1_req[core] <= '0;
endtask

task automatic test_read_miss_l2();
    coherence_pkg::addr_t addr;
    test_name = "read_miss_l2";
    addr      = random_addr();
    @(posedge clk_i);
    l1_req[1] <= make_req(1'b1, 1'b0, 1'b0, 1'b0, addr, '0);
    serve_miss_from_l2(1, addr, 1'b0, 1'b1);
    wait_for(EV_IDLE, 0, "return to idle");
endtask

task automatic test_read_miss_peer();
    coherence_pkg::addr_t addr;
    test_name    = "read_miss_peer";
    addr         = random_addr();
    held_line[1] = random_line();
    held_line[2] = random_line();
    @(posedge clk_i);
    l1_req[3] <= make_req(1'b1, 1'b0, 1'b0, 1'b0, addr, '0);
    wait_for(EV_PROBE, 0, "probe");
    check_probes(others_mask(3), 1'b0, addr);
    snoop_answer('b0110); // lower peer wins
    wait_for(EV_GRANT, 3, "grant");
    check_grant(3, 1'b1, 1'b0, held_line[1]);
    @(posedge clk_i);
    l1_req[3] <= '0;
    wait_for(EV_WRITE, 0, "L2 write-back");
    check_value("write replacement", 1'b0, l2_req.replacement);
    check_value("write line", held_line[1], l2_req.line);
    check_value("write addr", addr, l2_req.addr);
    l2_answer(1'b0, '0);
    wait_for(EV_IDLE, 0, "return to idle");
endtask

task automatic test_write_miss_peer();
    coherence_pkg::addr_t addr;
    int                   n;
    test_name    = "write_miss_peer";
    addr         = random_addr();
    held_line[2] = random_line();
    @(posedge clk_i);
    l1_req[0] <= make_req(1'b1, 1'b1, 1'b0, 1'b0, addr, '0);
    wait_for(EV_PROBE, 1, "probe");
    check_probes(others_mask(0), 1'b1, addr);
    snoop_answer('b0100);
    wait_for(EV_GRANT, 0, "grant");
    check_grant(0, 1'b1, 1'b0, held_line[2]);
    @(posedge clk_i);
    l1_req[0] <= '0;
    n = 0;
    @(negedge clk_i);
    while (dut_i.state != coherence_pkg::cu_idle && n < TIMEOUT) begin
        check_value("L2 write", 1'b0, l2_req.write); // peer copy is dirty, no write-back
        @(negedge clk_i);
        n++;
    end
    if (dut_i.state != coherence_pkg::cu_idle) begin
        report_timeout("return to idle");
    end
    check_value("L2 write", 1'b0, l2_req.write);
endtask

task automatic test_replacement();
    coherence_pkg::addr_t addr;
    coherence_pkg::line_t line;
    test_name = "replacement";
    addr      = random_addr();
    line      = random_line();
    @(posedge clk_i);
    l1_req[1] <= make_req(1'b0, 1'b0, 1'b0, 1'b1, addr, line);
    wait_for(EV_WRITE, 0, "L2 write");
    repeat (3) begin
        check_value("write held", 1'b1, l2_req.write);
        check_value("write replacement", 1'b1, l2_req.replacement);
        check_value("write line", line, l2_req.line);
        check_value("write addr", addr, l2_req.addr);
        check_value("early grant", 1'b0, l1_grant[1].ready);
        @(negedge clk_i);
    end
    l2_answer(1'b0, '0);
    wait_for(EV_GRANT, 1, "grant");
    check_grant(1, 1'b0, 1'b0, '0);
    check_value("write after ready", 1'b0, l2_req.write);
    @(posedge clk_i);
    l1_req[1] <= '0;
    wait_for(EV_IDLE, 0, "return to idle");
endtask

task automatic test_upgrade_priority();
    coherence_pkg::addr_t a1;
    coherence_pkg::addr_t a2;
    coherence_pkg::addr_t a3;
    test_name = "upgrade_priority";
    a1        = random_addr();
    a2        = random_addr();
    a3        = random_addr();
    @(posedge clk_i);
    l1_req[1] <= make_req(1'b1, 1'b0, 1'b0, 1'b0, a1, '0);
    l1_req[2] <= make_req(1'b0, 1'b1, 1'b1, 1'b0, a2, '0);
    l1_req[3] <= make_req(1'b1, 1'b1, 1'b0, 1'b0, a3, '0); // write miss
    wait_for(EV_GRANT, 2, "upgrade grant");
    check_grant(2, 1'b0, 1'b0, '0);
    check_probes(others_mask(2), 1'b1, a2);
    check_value("L2 invalidate", 1'b1, l2_req.invalidate);
    check_value("L2 invalidate addr", a2, l2_req.addr);
    @(posedge clk_i);
    l1_req[2] <= '0;
    serve_miss_from_l2(1, a1, 1'b0, 1'b0);
    serve_miss_from_l2(3, a3, 1'b1, 1'b1);
    wait_for(EV_IDLE, 0, "return to idle");
endtask

task automatic test_l2_back_invalidate();
    coherence_pkg::addr_t addr;
    test_name = "l2_back_invalidate";
    addr      = random_addr();
    @(posedge clk_i);
    l2_inval.strobe <= 1'b1;
    l2_inval.addr   <= addr;
    wait_for(EV_CU_READY, 0, "cu_l2_ready_o");
    check_probes('0, 1'b0, addr);
    @(posedge clk_i);
    l2_inval <= '0;
    @(negedge clk_i);
    check_probes('1, 1'b1, addr); // every core, requester or not
    check_value("cu_l2_ready_o", 1'b0, cu_l2_ready);
    wait_for(EV_IDLE, 0, "return to idle");
endtask

// ==== testbench/coherence_unit_tb.sv ====
`include "coherence_config.svh"
`default_nettype none

module coherence_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT     = 50; // cycles per wait
    localparam int EV_PROBE    = 0;
    localparam int EV_GRANT    = 1;
    localparam int EV_READ     = 2;
    localparam int EV_WRITE    = 3;
    localparam int EV_CU_READY = 4;
    localparam int EV_IDLE     = 5;

    logic                         clk_i;
    logic                         rst_i;
    coherence_pkg::l1_req_t       l1_req [0:`CU_CORE_NUMS-1];
    coherence_pkg::l1_snoop_rsp_t l1_snoop_rsp [0:`CU_CORE_NUMS-1];
    coherence_pkg::l1_probe_t     l1_probe [0:`CU_CORE_NUMS-1];
    coherence_pkg::l1_grant_t     l1_grant [0:`CU_CORE_NUMS-1];
    coherence_pkg::l2_rsp_t       l2_rsp;
    coherence_pkg::l2_inval_t     l2_inval;
    coherence_pkg::l2_req_t       l2_req;
    logic                         cu_l2_ready;
    coherence_pkg::line_t         held_line [0:`CU_CORE_NUMS-1]; // lines the peer L1s hold
    logic [31:0]                  lfsr_q;
    string                        test_name;

    coherence_unit dut_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .l1_req_i       (l1_req),
        .l1_snoop_rsp_i (l1_snoop_rsp),
        .l1_probe_o     (l1_probe),
        .l1_grant_o     (l1_grant),
        .l2_rsp_i       (l2_rsp),
        .l2_inval_i     (l2_inval),
        .l2_req_o       (l2_req),
        .cu_l2_ready_o  (cu_l2_ready)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [127:0] random_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[126:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic coherence_pkg::addr_t random_addr();
        logic [127:0] v;
        v = random_bits(28);
        return {v[27:0], 4'h0}; // line aligned
    endfunction

    function automatic coherence_pkg::line_t random_line();
        return random_bits(128);
    endfunction

    task automatic check_value(input string what, input logic [255:0] expected,
                               input logic [255:0] actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s: no %s seen within %0d cycles", test_name, what, TIMEOUT);
        $display("Testbench failed");
        $fatal(1);
    endtask

    function automatic logic seen(input int kind, input int core);
        case (kind)
            EV_PROBE:    return l1_probe[core].strobe;
            EV_GRANT:    return l1_grant[core].ready;
            EV_READ:     return l2_req.read_strobe;
            EV_WRITE:    return l2_req.write;
            EV_CU_READY: return cu_l2_ready;
            default:     return dut_i.state == coherence_pkg::cu_idle;
        endcase
    endfunction

    // outputs are looked at on the falling edge
    task automatic wait_for(input int kind, input int core, input string what);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!seen(kind, core) && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!seen(kind, core)) begin
            report_timeout(what);
        end
    endtask

    `include "coherence_tests.svh"

    initial begin
        lfsr_q    = 32'h1c75_8317;
        rst_i     = 1'b1;
        l2_rsp    = '0;
        l2_inval  = '0;
        test_name = "reset";
        for (int i = 0; i < `CU_CORE_NUMS; i++) begin
            l1_req[i]       = '0;
            l1_snoop_rsp[i] = '0;
            held_line[i]    = '0;
        end
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;
        test_read_miss_l2();
        test_read_miss_peer();
        test_write_miss_peer();
        test_replacement();
        test_upgrade_priority();
        test_l2_back_invalidate();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
+incdir+testbench
common/coherence_pkg.sv
coherence/l1_request_arbiter.sv
coherence/coherence_fsm.sv
coherence/snoop_response_unit.sv
coherence/l2_port.sv
verilog/coherence_unit.sv
testbench/coherence_unit_tb.sv
